//--- rtl/byteLane.sv
// Load alignment and extension, store alignment, byte merge and write mask
`timescale 1ns/1ps
`default_nettype none

module byteLane import lsuPkg::*; (
    input accessSizeT size,
    input offsetT offset,
    input lineT readLine,
    input wordT storeValue,
    input lineT refillLine,
    input logic refillWrite,
    input logic storeWrite,
    output wordT loadValue,
    output byteMaskT writeMask,
    output lineT writeLine
);
    lineT shiftedRead;
    lineT storeLine;
    byteMaskT storeMask;
    lineT mergedLine;

    always_comb begin
        shiftedRead = readLine >> {offset, 3'b000};
        case (size)
            SizeByte: loadValue = {{24{shiftedRead[7]}}, shiftedRead[7:0]};
            SizeHalf: loadValue = {{16{shiftedRead[15]}}, shiftedRead[15:0]};
            SizeUnsignedByte: loadValue = {24'h0, shiftedRead[7:0]};
            SizeUnsignedHalf: loadValue = {16'h0, shiftedRead[15:0]};
            default: loadValue = shiftedRead[31:0];
        endcase
    end

    always_comb begin
        case (size)
            SizeByte, SizeUnsignedByte: storeMask = byteMaskT'(1);
            SizeHalf, SizeUnsignedHalf: storeMask = byteMaskT'(3);
            default: storeMask = byteMaskT'(15);
        endcase
        storeMask = storeMask << offset;
        storeLine = lineT'(storeValue) << {offset, 3'b000};

        // Full merged line for the write-through
        for (int i = 0; i < LineBytes; i++) begin
            mergedLine[i*8 +: 8] = storeMask[i] ? storeLine[i*8 +: 8] : readLine[i*8 +: 8];
        end
    end

    assign writeLine = refillWrite ? refillLine : mergedLine;
    assign writeMask = refillWrite ? {LineBytes{1'b1}}
                                   : (storeWrite ? storeMask : {LineBytes{1'b0}});

endmodule

`default_nettype wire

//--- rtl/cacheArrays.sv
// Direct-mapped valid/tag RAM and byte-masked data RAM with registered reads
`timescale 1ns/1ps
`default_nettype none

module cacheArrays import lsuPkg::*; #(
    parameter int IndexWidth = 4,
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth,
    localparam int Depth = 1 << IndexWidth
) (
    input logic clk,
    input logic rst,
    input logic [IndexWidth-1:0] index,
    input logic tagWrite,
    input logic [TagWidth-1:0] writeTag,
    input byteMaskT dataMask,
    input lineT writeLine,
    output logic readValid,
    output logic [TagWidth-1:0] readTag,
    output lineT readLine
);
    logic [Depth-1:0] validBits;
    logic [TagWidth-1:0] tagMem [Depth];
    lineT dataMem [Depth];

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            readValid <= 1'b0;
        end else begin
            if (tagWrite) begin
                validBits[index] <= 1'b1;
            end
            readValid <= validBits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagWrite) begin
            tagMem[index] <= writeTag;
        end
        readTag <= tagMem[index];
    end

    // Read returns the old line when written in the same cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < LineBytes; i++) begin
            if (dataMask[i]) begin
                dataMem[index][i*8 +: 8] <= writeLine[i*8 +: 8];
            end
        end
        readLine <= dataMem[index];
    end

    // Control and replacer are both idle right after reset
    assert property (@(posedge clk) $past(rst) |-> (dataMask == '0 && !tagWrite));

endmodule

`default_nettype wire

//--- rtl/lineReplacer.sv
// Memory sequencer for line refill and line write-through
`timescale 1ns/1ps
`default_nettype none

module lineReplacer import lsuPkg::*; #(
    parameter int IndexWidth = 4,
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth
) (
    input logic clk,
    input logic rst,
    input logic refillStart,
    input logic writeThroughStart,
    input logic [TagWidth+IndexWidth-1:0] lineAddr,
    input lineT mergedLine,
    input memResponseT memResp,
    output memRequestT memReq,
    output lineT refillLine,
    output logic refillWrite,
    output logic replacerDone
);
    typedef enum logic [1:0] {
        ReplaceIdle,
        ReplaceRead,
        ReplaceWrite
    } replaceStateT;

    replaceStateT state;
    logic [TagWidth+IndexWidth-1:0] addrReg;
    lineT lineReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ReplaceIdle;
        end else begin
            case (state)
                ReplaceIdle: begin
                    if (refillStart) begin
                        state <= ReplaceRead;
                    end else if (writeThroughStart) begin
                        state <= ReplaceWrite;
                    end
                end
                ReplaceRead: begin
                    if (memResp.readGrant) begin
                        state <= ReplaceIdle;
                    end
                end
                ReplaceWrite: begin
                    if (memResp.writeGrant) begin
                        state <= ReplaceIdle;
                    end
                end
                default: begin
                    state <= ReplaceIdle;
                end
            endcase
        end
    end

    // Held stable for the whole request
    always_ff @(posedge clk) begin
        if (state == ReplaceIdle && (refillStart || writeThroughStart)) begin
            addrReg <= lineAddr;
        end
        if (state == ReplaceIdle && writeThroughStart) begin
            lineReg <= mergedLine;
        end
    end

    always_comb begin
        memReq.readReq = (state == ReplaceRead);
        memReq.writeReq = (state == ReplaceWrite);
        memReq.lineAddr = addrReg;
        memReq.writeLine = lineReg;
    end

    assign refillLine = memResp.readLine;
    assign refillWrite = (state == ReplaceRead) && memResp.readGrant;
    assign replacerDone = refillWrite || ((state == ReplaceWrite) && memResp.writeGrant);

    assert property (@(posedge clk) disable iff (rst)
        !(memReq.readReq && memReq.writeReq));

    // Control never starts a transfer while one is in flight
    assert property (@(posedge clk) disable iff (rst)
        (refillStart || writeThroughStart) |-> state == ReplaceIdle);

endmodule

`default_nettype wire

//--- rtl/loadStoreUnit.sv
// Load/store unit top level with control, cache arrays, byte lanes and line replacer
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit import lsuPkg::*; #(
    parameter int IndexWidth = 4,
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input lsuRequestT request,
    output logic done,
    output wordT result,
    output memRequestT memReq,
    input memResponseT memResp
);
    lsuRequestT latched;
    logic [IndexWidth-1:0] arrayIndex;
    logic tagWrite;
    logic [TagWidth-1:0] writeTag;
    logic dataWriteSel;
    logic refillStart;
    logic writeThroughStart;

    logic readValid;
    logic [TagWidth-1:0] readTag;
    lineT readLine;

    byteMaskT writeMask;
    lineT writeLine;
    lineT refillLine;
    logic refillWrite;
    logic replacerDone;

    lsuControl #(
        .IndexWidth(IndexWidth)
    ) control_i (
        .clk,
        .rst,
        .enable,
        .request,
        .readTag,
        .readValid,
        .refillWrite,
        .replacerDone,
        .done,
        .latched,
        .arrayIndex,
        .tagWrite,
        .writeTag,
        .dataWriteSel,
        .refillStart,
        .writeThroughStart
    );

    cacheArrays #(
        .IndexWidth(IndexWidth)
    ) arrays_i (
        .clk,
        .rst,
        .index(arrayIndex),
        .tagWrite,
        .writeTag,
        .dataMask(writeMask),
        .writeLine,
        .readValid,
        .readTag,
        .readLine
    );

    byteLane lane_i (
        .size(latched.size),
        .offset(latched.addr[OffsetWidth-1:0]),
        .readLine,
        .storeValue(latched.storeValue),
        .refillLine,
        .refillWrite,
        .storeWrite(dataWriteSel),
        .loadValue(result),
        .writeMask,
        .writeLine
    );

    // Merged store line doubles as the write-through payload
    lineReplacer #(
        .IndexWidth(IndexWidth)
    ) replacer_i (
        .clk,
        .rst,
        .refillStart,
        .writeThroughStart,
        .lineAddr(latched.addr[AddrWidth-1:OffsetWidth]),
        .mergedLine(writeLine),
        .memResp,
        .memReq,
        .refillLine,
        .refillWrite,
        .replacerDone
    );

endmodule

`default_nettype wire

//--- rtl/lsuControl.sv
// Load/store FSM with request latch, tag compare, array control and done strobe
`timescale 1ns/1ps
`default_nettype none

module lsuControl import lsuPkg::*; #(
    parameter int IndexWidth = 4,
    localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth
) (
    input logic clk,
    input logic rst,
    input logic enable,
    input lsuRequestT request,
    input logic [TagWidth-1:0] readTag,
    input logic readValid,
    input logic refillWrite,
    input logic replacerDone,
    output logic done,
    output lsuRequestT latched,
    output logic [IndexWidth-1:0] arrayIndex,
    output logic tagWrite,
    output logic [TagWidth-1:0] writeTag,
    output logic dataWriteSel,
    output logic refillStart,
    output logic writeThroughStart
);
    lsuStateT state;
    lsuStateT nextState;
    logic hit;

    assign hit = readValid && (readTag == latched.addr[AddrWidth-1:OffsetWidth+IndexWidth]);

    // Idle presents the incoming index so the arrays are read by the Load/Store cycle
    assign arrayIndex = (state == StateIdle) ? request.addr[OffsetWidth +: IndexWidth]
                                             : latched.addr[OffsetWidth +: IndexWidth];

    assign tagWrite = (state == StateRefill) && refillWrite;
    assign writeTag = latched.addr[AddrWidth-1:OffsetWidth+IndexWidth];

    always_comb begin
        nextState = state;
        done = 1'b0;
        dataWriteSel = 1'b0;
        refillStart = 1'b0;
        writeThroughStart = 1'b0;
        case (state)
            StateIdle: begin
                if (enable && request.command == CommandLoad) begin
                    nextState = StateLoad;
                end else if (enable && request.command == CommandStore) begin
                    nextState = StateStore;
                end
            end
            StateLoad: begin
                if (hit) begin
                    done = 1'b1;
                    nextState = StateIdle;
                end else begin
                    refillStart = 1'b1;
                    nextState = StateRefill;
                end
            end
            StateStore: begin
                if (hit) begin
                    dataWriteSel = 1'b1;
                    writeThroughStart = 1'b1;
                    nextState = StateWriteThrough;
                end else begin
                    refillStart = 1'b1;
                    nextState = StateRefill;
                end
            end
            // No done since the held request is accepted again and hits
            StateRefill: begin
                if (replacerDone) begin
                    nextState = StateIdle;
                end
            end
            StateWriteThrough: begin
                if (replacerDone) begin
                    done = 1'b1;
                    nextState = StateIdle;
                end
            end
            default: begin
                nextState = StateIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == StateIdle && enable) begin
            latched <= request;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (state == StateIdle || state == StateRefill) |-> !done);

    assert property (@(posedge clk) disable iff (rst)
        !(refillStart && writeThroughStart));

endmodule

`default_nettype wire

//--- rtl/lsuPkg.sv
// Line geometry, access enums, request struct and memory request/response structs
`default_nettype none

package lsuPkg;

    localparam int LineBytes = 8;
    localparam int AddrWidth = 32;
    localparam int OffsetWidth = $clog2(LineBytes);

    typedef logic [LineBytes*8-1:0] lineT;
    typedef logic [LineBytes-1:0] byteMaskT;
    typedef logic [OffsetWidth-1:0] offsetT;
    typedef logic [31:0] wordT;

    typedef enum logic [1:0] {
        CommandNone,
        CommandLoad,
        CommandStore
    } lsuCommandT;

    // Unsigned sizes only matter for loads
    typedef enum logic [2:0] {
        SizeByte,
        SizeHalf,
        SizeWord,
        SizeUnsignedByte,
        SizeUnsignedHalf
    } accessSizeT;

    typedef enum logic [2:0] {
        StateIdle,
        StateLoad,
        StateStore,
        StateRefill,
        StateWriteThrough
    } lsuStateT;

    typedef struct packed {
        lsuCommandT command;
        accessSizeT size;
        logic [AddrWidth-1:0] addr;
        wordT storeValue;
    } lsuRequestT;

    typedef struct packed {
        logic readReq;
        logic writeReq;
        logic [AddrWidth-OffsetWidth-1:0] lineAddr;
        lineT writeLine;
    } memRequestT;

    typedef struct packed {
        logic readGrant;
        logic writeGrant;
        lineT readLine;
    } memResponseT;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tbLoadStoreUnit -f tb.f
./obj_dir/VtbLoadStoreUnit > sim.log 2>&1 || true
cat sim.log
if grep -qx "Done: no errors" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

//--- tb.f
rtl/lsuPkg.sv
rtl/byteLane.sv
rtl/cacheArrays.sv
rtl/lineReplacer.sv
rtl/lsuControl.sv
rtl/loadStoreUnit.sv
test/memModel.sv
test/tbLoadStoreUnit.sv

//--- test/memModel.sv
// Line-wide memory model with random grant delay, preload port and backing store peek port
`timescale 1ns/1ps
`default_nettype none

module memModel import lsuPkg::*; #(
    parameter int MemLines = 64,
    localparam int LineIndexWidth = $clog2(MemLines)
) (
    input logic clk,
    input logic rst,
    input memRequestT memReq,
    output memResponseT memResp,
    input logic preloadEnable,
    input logic [LineIndexWidth-1:0] preloadAddr,
    input lineT preloadLine,
    input logic [LineIndexWidth-1:0] peekAddr,
    output lineT peekLine
);
    lineT store [MemLines];
    logic busy;
    logic [2:0] countdown;
    logic [31:0] byteAddr;
    logic [LineIndexWidth-1:0] lineIndex;

    assign lineIndex = memReq.lineAddr[LineIndexWidth-1:0];
    assign peekLine = store[peekAddr];

    always @(posedge clk) begin
        if (rst) begin
            // Fill from the byte address until preloaded
            for (int i = 0; i < MemLines; i++) begin
                for (int b = 0; b < LineBytes; b++) begin
                    byteAddr = 32'(i * LineBytes + b);
                    store[i][b*8 +: 8] = byteAddr[7:0] ^ byteAddr[15:8] ^ 8'h5a;
                end
            end
            memResp <= '0;
            busy <= 1'b0;
            countdown <= 3'd0;
        end else begin
            if (preloadEnable) begin
                store[preloadAddr] = preloadLine;
            end
            memResp.readGrant <= 1'b0;
            memResp.writeGrant <= 1'b0;
            // Grant cycle still shows the request, so it must not restart
            if (!busy && (memReq.readReq || memReq.writeReq)
                    && !memResp.readGrant && !memResp.writeGrant) begin
                busy <= 1'b1;
                countdown <= 3'($urandom_range(5, 0));
            end else if (busy) begin
                if (countdown == 3'd0) begin
                    busy <= 1'b0;
                    if (memReq.readReq) begin
                        memResp.readGrant <= 1'b1;
                        memResp.readLine <= store[lineIndex];
                    end else begin
                        memResp.writeGrant <= 1'b1;
                        store[lineIndex] = memReq.writeLine;
                    end
                end else begin
                    countdown <= countdown - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tbLoadStoreUnit.sv
// Load/store unit testbench with memory model, shadow memory and checking assertions
`timescale 1ns/1ps
`default_nettype none

module tbLoadStoreUnit
    import lsuPkg::*;
();
    localparam int TimeoutCycles = 200;
    localparam int MemLines = 64;

    logic clk, rst, enable, done;
    lsuRequestT request;
    wordT result, expectedResult;
    memRequestT memReq;
    memResponseT memResp;
    logic preloadEnable, checkLoad, checkStore;
    logic [5:0] preloadAddr, peekAddr;
    lineT preloadLine, peekLine, expectedLine;
    logic [7:0] shadow [MemLines*LineBytes];
    int errorCount, testCount, failedTests, testStartErrors;

    loadStoreUnit #(
        .IndexWidth(4)
    ) dut_i (
        .clk, .rst, .enable, .request, .done, .result, .memReq, .memResp
    );

    memModel #(
        .MemLines(MemLines)
    ) mem_i (
        .clk, .rst, .memReq, .memResp, .preloadEnable, .preloadAddr, .preloadLine,
        .peekAddr, .peekLine
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (rst)
        !enable |-> !done && !memReq.readReq && !memReq.writeReq)
    else begin
        errorCount++;
        $display("FAILED done/readReq/writeReq while idle: %h/%h/%h", $sampled(done),
                 $sampled(memReq.readReq), $sampled(memReq.writeReq));
    end

    assert property (@(posedge clk) disable iff (rst)
        done && checkLoad |-> result == expectedResult)
    else begin
        errorCount++;
        $display("FAILED result: got %h, expected %h", $sampled(result), $sampled(expectedResult));
    end

    // Backing line is written by the grant, so compare one cycle after done
    assert property (@(posedge clk) disable iff (rst)
        done && checkStore |=> peekLine == expectedLine)
    else begin
        errorCount++;
        $display("FAILED memModel line %h: got %h, expected %h", $sampled(peekAddr),
                 $sampled(peekLine), $sampled(expectedLine));
    end

    function automatic int sizeBytes(input accessSizeT size);
        case (size)
            SizeWord: return 4;
            SizeHalf, SizeUnsignedHalf: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic accessSizeT sizeFromCode(input logic [2:0] code);
        case (code)
            3'd0: return SizeByte;
            3'd1: return SizeHalf;
            3'd3: return SizeUnsignedByte;
            3'd4: return SizeUnsignedHalf;
            default: return SizeWord;
        endcase
    endfunction

    // Naturally aligned offset inside the given line
    function automatic logic [31:0] randomAddress(input logic [5:0] lineNum,
                                                  input accessSizeT size);
        logic [31:0] rnd;
        logic [2:0] offset;
        rnd = $urandom();
        case (size)
            SizeWord: offset = {rnd[0], 2'b00};
            SizeHalf, SizeUnsignedHalf: offset = {rnd[1:0], 1'b0};
            default: offset = rnd[2:0];
        endcase
        return {23'b0, lineNum, offset};
    endfunction

    function automatic wordT loadExpect(input logic [8:0] a, input accessSizeT size);
        wordT raw;
        raw = {shadow[a + 9'd3], shadow[a + 9'd2], shadow[a + 9'd1], shadow[a]};
        case (size)
            SizeByte: return {{24{raw[7]}}, raw[7:0]};
            SizeHalf: return {{16{raw[15]}}, raw[15:0]};
            SizeUnsignedByte: return {24'h0, raw[7:0]};
            SizeUnsignedHalf: return {16'h0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    // Shadow line with the store's bytes already in place
    function automatic lineT storeExpect(input logic [8:0] a, input accessSizeT size,
                                         input wordT value);
        lineT line;
        int i;
        for (i = 0; i < LineBytes; i++) begin
            line[i*8 +: 8] = shadow[{a[8:3], 3'(i)}];
        end
        for (i = 0; i < sizeBytes(size); i++) begin
            line[(int'(a[2:0]) + i)*8 +: 8] = value[i*8 +: 8];
        end
        return line;
    endfunction

    task automatic access(input lsuCommandT command, input accessSizeT size,
                          input logic [31:0] addr, input wordT value);
        lsuRequestT req;
        int cycles;
        int i;
        req.command = command;
        req.size = size;
        req.addr = addr;
        req.storeValue = value;
        @(posedge clk);
        request <= req;
        enable <= 1'b1;
        peekAddr <= addr[8:3];
        checkLoad <= (command == CommandLoad);
        checkStore <= (command == CommandStore);
        expectedResult <= loadExpect(addr[8:0], size);
        expectedLine <= storeExpect(addr[8:0], size, value);
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < TimeoutCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: no done within %0d cycles for address %h", TimeoutCycles, addr);
            $display("Done: errors found");
            $finish;
        end else begin
            @(posedge clk);
            enable <= 1'b0;
            if (command == CommandStore) begin
                for (i = 0; i < sizeBytes(size); i++) begin
                    shadow[addr[8:0] + 9'(i)] = value[i*8 +: 8];
                end
            end
        end
    endtask

    task automatic preloadMemory();
        lineT line;
        int i;
        int b;
        for (i = 0; i < MemLines; i++) begin
            line[31:0] = $urandom();
            line[63:32] = $urandom();
            for (b = 0; b < LineBytes; b++) begin
                shadow[{6'(i), 3'(b)}] = line[b*8 +: 8];
            end
            @(posedge clk);
            preloadEnable <= 1'b1;
            preloadAddr <= 6'(i);
            preloadLine <= line;
        end
        @(posedge clk);
        preloadEnable <= 1'b0;
    endtask

    task automatic finishTest(input string name);
        repeat (2) @(posedge clk);
        testCount++;
        if (errorCount == testStartErrors) begin
            $display("Test %0d (%s) finished: pass", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d (%s) finished: %0d errors", testCount, name,
                     errorCount - testStartErrors);
        end
        testStartErrors = errorCount;
    endtask

    initial begin
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [1:0] tagA;
        logic [1:0] tagB;
        logic [3:0] index;
        accessSizeT size;
        int n;
        void'($urandom(32'h83589c2f));
        errorCount = 0;
        testCount = 0;
        failedTests = 0;
        testStartErrors = 0;
        rst = 1'b1;
        enable = 1'b0;
        request = '0;
        preloadEnable = 1'b0;
        preloadAddr = '0;
        preloadLine = '0;
        peekAddr = '0;
        checkLoad = 1'b0;
        checkStore = 1'b0;
        expectedResult = '0;
        expectedLine = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        repeat (10) @(posedge clk);
        finishTest("idle after reset");

        preloadMemory();
        for (n = 0; n < 24; n++) begin
            rnd = $urandom();
            size = sizeFromCode(rnd[2:0]);
            access(CommandLoad, size, randomAddress(rnd[13:8], size), '0);
        end
        finishTest("loads from preloaded lines");

        for (n = 0; n < 12; n++) begin
            rnd = $urandom();
            size = rnd[0] ? SizeHalf : SizeByte;
            addr = randomAddress(rnd[13:8], size);
            access(CommandStore, size, addr, $urandom());
            access(CommandLoad, SizeWord, {addr[31:3], addr[2], 2'b00}, '0);
        end
        finishTest("partial store then word load");

        // Top bit forced so signed and unsigned results differ
        for (n = 0; n < 8; n++) begin
            rnd = $urandom();
            addr = randomAddress(rnd[13:8], SizeHalf);
            access(CommandStore, SizeHalf, addr, {16'h0, 1'b1, rnd[30:16]});
            access(CommandLoad, SizeHalf, addr, '0);
            access(CommandLoad, SizeUnsignedHalf, addr, '0);
            access(CommandStore, SizeByte, addr, {24'h0, 1'b1, rnd[22:16]});
            access(CommandLoad, SizeByte, addr, '0);
            access(CommandLoad, SizeUnsignedByte, addr, '0);
        end
        finishTest("sign and zero extension");

        for (n = 0; n < 20; n++) begin
            rnd = $urandom();
            size = sizeFromCode(rnd[2:0]);
            access(CommandStore, size, randomAddress(rnd[13:8], size), $urandom());
        end
        finishTest("store write-through");

        rnd = $urandom();
        index = rnd[3:0];
        tagA = rnd[5:4];
        tagB = tagA ^ ((rnd[7:6] == 2'b00) ? 2'b01 : rnd[7:6]);
        for (n = 0; n < 32; n++) begin
            rnd = $urandom();
            size = sizeFromCode(rnd[2:0]);
            addr = randomAddress({n[0] ? tagB : tagA, index}, size);
            access(rnd[3] ? CommandStore : CommandLoad, size, addr, $urandom());
        end
        finishTest("eviction between two tags");

        $display("Tests run: %0d, tests failed: %0d, check errors: %0d", testCount,
                 failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
